/* source/exu_macros.svh */
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// datapath widths
`define EXU_WIDTH  32
`define EXU_IWIDTH 16

// general register count
`define EXU_NREGS  16

// bit positions in the flag register
`define EXU_CIDX   0  // carry
`define EXU_ZIDX   1  // zero
`define EXU_SIDX   2  // sign
`define EXU_VIDX   3  // overflow
`define EXU_PIDX   4
`define EXU_UIDX   5
`define EXU_N1IDX  6
`define EXU_N2IDX  7

`endif

/* source/exu_pkg.sv */
`include "exu_macros.svh"

package exu_pkg;

   typedef logic [`EXU_WIDTH-1:0]         word_t;
   typedef logic [`EXU_IWIDTH-1:0]        imm_t;
   typedef logic [5:0]                    op_t;
   typedef logic [$clog2(`EXU_NREGS)-1:0] reg_idx_t;
   typedef logic [7:0]                    flags_t;

   // request payload, rd is destination and first source
   typedef struct packed {
      op_t      op;
      reg_idx_t rd;
      reg_idx_t rb;
      imm_t     imm;
   } instr_t;

   typedef struct packed {
      logic     valid;
      op_t      op;
      reg_idx_t rd;
      word_t    di;  // rd contents
      word_t    bi;  // rb contents
      imm_t     im;
      flags_t   fi;  // flags at issue
   } issue_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    res;
      flags_t   fo;  // flags after the instruction
      logic     wb_en;
      logic     flag_en;
   } exec_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    data;
      flags_t   flags;
      logic     wb_en;
      logic     flag_en;
   } retire_t;

   typedef enum logic [1:0] {
      IS_IDLE,
      IS_ACKED,
      IS_WAIT_LOW
   } issue_state_t;

endpackage

/* source/issue_stage.sv */
`timescale 1ns/10ps

module issue_stage (
   input  logic              clk,
   input  logic              rst,
   input  logic              req,
   input  exu_pkg::instr_t   instr,
   output logic              ack,
   output exu_pkg::reg_idx_t rd_idx,
   output exu_pkg::reg_idx_t rb_idx,
   input  exu_pkg::word_t    rd_data,
   input  exu_pkg::word_t    rb_data,
   input  exu_pkg::flags_t   flags,
   output exu_pkg::issue_t   issue
);

   exu_pkg::issue_state_t state;
   exu_pkg::issue_state_t state_nxt;
   logic                  capture;

   // register file is read straight from the request payload
   assign rd_idx  = instr.rd;
   assign rb_idx  = instr.rb;
   assign capture = req && (state == exu_pkg::IS_IDLE);
   assign ack     = (state != exu_pkg::IS_IDLE);

   always_comb begin
      state_nxt = state;
      case (state)
         exu_pkg::IS_IDLE: begin
            if (req)
               state_nxt = exu_pkg::IS_ACKED;
         end
         exu_pkg::IS_ACKED: begin
            if (req)
               state_nxt = exu_pkg::IS_WAIT_LOW;
            else
               state_nxt = exu_pkg::IS_IDLE;  // req already dropped
         end
         default: begin
            if (!req)
               state_nxt = exu_pkg::IS_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         state <= exu_pkg::IS_IDLE;
      else
         state <= state_nxt;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         issue.valid <= 1'b0;
      end else begin
         issue.valid <= capture;
         if (capture) begin
            issue.op <= instr.op;
            issue.rd <= instr.rd;
            issue.di <= rd_data;
            issue.bi <= rb_data;
            issue.im <= instr.imm;
            issue.fi <= flags;
         end
      end
   end

   ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> $past(req));

   issue_one_cycle: assert property (@(posedge clk) disable iff (rst)
      issue.valid |=> !issue.valid);

endmodule

/* source/reg_file.sv */
`timescale 1ns/10ps
`include "exu_macros.svh"

module reg_file (
   input  logic              clk,
   input  logic              rst,
   input  exu_pkg::reg_idx_t rd_idx,
   input  exu_pkg::reg_idx_t rb_idx,
   output exu_pkg::word_t    rd_data,
   output exu_pkg::word_t    rb_data,
   output exu_pkg::flags_t   flags,
   input  logic              reg_we,
   input  exu_pkg::reg_idx_t reg_widx,
   input  exu_pkg::word_t    reg_wdata,
   input  logic              flag_we,
   input  exu_pkg::flags_t   flag_wdata
);

   exu_pkg::word_t  regs [`EXU_NREGS];
   exu_pkg::flags_t flag_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `EXU_NREGS; i++)
            regs[i] <= '0;
      end else if (reg_we) begin
         regs[reg_widx] <= reg_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         flag_q <= '0;
      else if (flag_we)
         flag_q <= flag_wdata;
   end

   // async read ports, no bypass needed with one op in flight
   assign rd_data = regs[rd_idx];
   assign rb_data = regs[rb_idx];
   assign flags   = flag_q;

endmodule

/* source/alu.sv */
`timescale 1ns/10ps
`include "exu_macros.svh"

module alu (
   input  exu_pkg::issue_t issue,
   output exu_pkg::word_t  res,
   output exu_pkg::flags_t fo,
   output logic            wb_en,
   output logic            flag_en
);

   exu_pkg::op_t   op;
   logic [3:0]     code;
   exu_pkg::word_t di;
   logic           ci;
   logic           op_2reg;
   logic           op_2im;
   logic           op_1;
   logic           wr_flags;

   exu_pkg::word_t zex_im;
   exu_pkg::word_t sex_im;
   exu_pkg::word_t oex_im;
   exu_pkg::word_t op2;

   exu_pkg::word_t add_a;
   exu_pkg::word_t add_b;
   logic           cin;
   exu_pkg::word_t res_add;
   logic           c_add;
   logic           v_add;

   exu_pkg::word_t res_sed;
   exu_pkg::word_t res_2;
   exu_pkg::word_t res_1;
   logic           co_1;

   assign op       = issue.op;
   assign code     = issue.op[3:0];
   assign di       = issue.di;
   assign ci       = issue.fi[`EXU_CIDX];
   assign op_1     = op[5];
   assign op_2im   = ~op[5] & op[4];
   assign op_2reg  = ~op[5] & ~op[4];
   assign wr_flags = (op == 6'h2f);

   assign zex_im = {{(`EXU_WIDTH-`EXU_IWIDTH){1'b0}}, issue.im};
   assign sex_im = {{(`EXU_WIDTH-`EXU_IWIDTH){issue.im[`EXU_IWIDTH-1]}}, issue.im};
   assign oex_im = {{(`EXU_WIDTH-`EXU_IWIDTH){1'b1}}, issue.im};

   always_comb begin
      if (op_2reg) begin
         op2 = issue.bi;
      end else begin
         case (code)
            4'h0, 4'h1, 4'h2, 4'h3, 4'hb, 4'hc, 4'hd, 4'he: op2 = zex_im;
            4'hf:    op2 = oex_im;  // and with upper half kept
            default: op2 = sex_im;
         endcase
      end
   end

   // shared adder
   always_comb begin
      add_a = di;
      add_b = op2;
      cin   = ci;
      case (code)
         4'h4, 4'ha: cin = 1'b0;
         4'h6, 4'h8: begin
            add_b = ~op2;
            cin   = 1'b1;
         end
         4'h7:    add_b = ~op2;  // borrow in through C
         default: ;
      endcase
      if (op_1 && code == 4'h5) begin  // neg as 0 - di
         add_a = '0;
         add_b = ~di;
         cin   = 1'b1;
      end
   end

   assign {c_add, res_add} = {1'b0, add_a} + {1'b0, add_b} + {{`EXU_WIDTH{1'b0}}, cin};
   assign v_add = (add_a[`EXU_WIDTH-1] == add_b[`EXU_WIDTH-1]) &&
                  (res_add[`EXU_WIDTH-1] != add_a[`EXU_WIDTH-1]);

   assign res_sed = {`EXU_WIDTH{op2[`EXU_WIDTH-1]}};

   always_comb begin
      case (code)
         4'h0: res_2 = op_2reg ? op2 : {di[`EXU_WIDTH-1:`EXU_IWIDTH], op2[`EXU_IWIDTH-1:0]};
         4'h1: res_2 = op_2reg ? di : {op2[`EXU_IWIDTH-1:0], di[`EXU_IWIDTH-1:0]};
         4'h2: res_2 = op_2reg ? di : op2;  // op2 already zero extended
         4'h3: res_2 = res_sed;
         4'h4, 4'h5, 4'h6, 4'h7, 4'h8, 4'ha: res_2 = res_add;
         4'h9: res_2 = di * op2;  // low word only
         4'hb, 4'hc, 4'hf: res_2 = di & op2;
         4'hd: res_2 = di | op2;
         default: res_2 = di ^ op2;
      endcase
   end

   // single operand group with co_1 as the bit pushed out
   always_comb begin
      res_1 = di;
      co_1  = ci;
      case (code)
         4'h0: res_1 = {{(`EXU_WIDTH-8){1'b0}}, di[7:0]};
         4'h1: res_1 = {{(`EXU_WIDTH-`EXU_IWIDTH){1'b0}}, di[`EXU_IWIDTH-1:0]};
         4'h2: res_1 = {{(`EXU_WIDTH-8){di[7]}}, di[7:0]};
         4'h3: res_1 = {{(`EXU_WIDTH-`EXU_IWIDTH){di[`EXU_IWIDTH-1]}}, di[`EXU_IWIDTH-1:0]};
         4'h4: res_1 = ~di;
         4'h5: begin
            res_1 = res_add;
            co_1  = c_add;
         end
         4'h6: begin
            res_1 = {ci, di[`EXU_WIDTH-1:1]};
            co_1  = di[0];
         end
         4'h7: begin
            res_1 = {di[`EXU_WIDTH-2:0], ci};
            co_1  = di[`EXU_WIDTH-1];
         end
         4'h8: begin
            res_1 = {di[`EXU_WIDTH-2:0], 1'b0};
            co_1  = di[`EXU_WIDTH-1];
         end
         4'h9: begin
            res_1 = {1'b0, di[`EXU_WIDTH-1:1]};
            co_1  = di[0];
         end
         4'ha: begin
            res_1 = {di[`EXU_WIDTH-1], di[`EXU_WIDTH-1:1]};
            co_1  = di[0];
         end
         4'hc:    co_1 = 1'b1;  // set carry
         4'hd:    co_1 = 1'b0;  // clear carry
         4'he:    res_1 = {{(`EXU_WIDTH-8){1'b0}}, issue.fi};
         default: ;
      endcase
   end

   assign res = op_1 ? res_1 : res_2;

   always_comb begin
      fo = issue.fi;
      fo[`EXU_ZIDX] = ~|res;
      fo[`EXU_SIDX] = res[`EXU_WIDTH-1];
      if (op_1) begin
         fo[`EXU_CIDX] = co_1;
      end else if (code >= 4'h4 && code <= 4'h8) begin
         fo[`EXU_CIDX] = c_add;
         fo[`EXU_VIDX] = v_add;
      end
      if (wr_flags)
         fo = di[7:0];  // whole flag register from di
   end

   // per class enable decode where cmp and test leave rd alone
   assign wb_en = op_2reg & (op[2] & ~op[3] | op[2] & op[1] | ~op[0] & ~op[3] & ~op[1] |
                             op[0] & op[3] & ~op[1] | op[0] & ~op[3] & op[1] |
                             ~op[0] & op[3] & op[1]) |
                  op_2im & (~op[3] | op[2] & op[1] | op[0] & op[2] | (op[0] ^ op[1])) |
                  op_1 & (~op[3] | ~op[1] & ~op[2] | ~op[0] & ~op[2] | ~op[0] & op[1]);

   assign flag_en = (op_2reg | op_2im) & (op[2] | op[3] & ~op[1]) |
                    op_1 & ((op[3] ^ op[2]) | op[3] & ~op[1] | op[2] & op[0]);

   always_comb begin
      if (issue.valid && op == 6'h08)
         cmp_no_wb: assert final (!wb_en);
   end

endmodule

/* source/writeback_stage.sv */
`timescale 1ns/10ps

module writeback_stage (
   input  logic              clk,
   input  logic              rst,
   input  exu_pkg::issue_t   issue,
   input  exu_pkg::word_t    res,
   input  exu_pkg::flags_t   fo,
   input  logic              wb_en,
   input  logic              flag_en,
   output logic              reg_we,
   output exu_pkg::reg_idx_t reg_widx,
   output exu_pkg::word_t    reg_wdata,
   output logic              flag_we,
   output exu_pkg::flags_t   flag_wdata,
   output exu_pkg::retire_t  retire
);

   exu_pkg::exec_t exec_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         exec_q.valid <= 1'b0;
      end else begin
         exec_q.valid <= issue.valid;
         if (issue.valid) begin
            exec_q.rd      <= issue.rd;
            exec_q.res     <= res;
            exec_q.fo      <= flag_en ? fo : issue.fi;  // flags as they stand after commit
            exec_q.wb_en   <= wb_en;
            exec_q.flag_en <= flag_en;
         end
      end
   end

   // strobes live for one cycle, write lands on the next edge
   assign reg_we     = exec_q.valid & exec_q.wb_en;
   assign reg_widx   = exec_q.rd;
   assign reg_wdata  = exec_q.res;
   assign flag_we    = exec_q.valid & exec_q.flag_en;
   assign flag_wdata = exec_q.fo;

   always_ff @(posedge clk) begin
      if (rst) begin
         retire.valid <= 1'b0;
      end else begin
         retire.valid <= exec_q.valid;
         if (exec_q.valid) begin
            retire.rd      <= exec_q.rd;
            retire.data    <= exec_q.res;
            retire.flags   <= exec_q.fo;
            retire.wb_en   <= exec_q.wb_en;
            retire.flag_en <= exec_q.flag_en;
         end
      end
   end

endmodule

/* source/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit (
   input  logic             clk,
   input  logic             rst,
   input  logic             req,
   input  exu_pkg::instr_t  instr,
   output logic             ack,
   output exu_pkg::retire_t retire
);

   exu_pkg::reg_idx_t rd_idx;
   exu_pkg::reg_idx_t rb_idx;
   exu_pkg::word_t    rd_data;
   exu_pkg::word_t    rb_data;
   exu_pkg::flags_t   flags;
   exu_pkg::issue_t   issue;

   exu_pkg::word_t    res;
   exu_pkg::flags_t   fo;
   logic              wb_en;
   logic              flag_en;

   logic              reg_we;
   exu_pkg::reg_idx_t reg_widx;
   exu_pkg::word_t    reg_wdata;
   logic              flag_we;
   exu_pkg::flags_t   flag_wdata;

   issue_stage issue_i (
      .clk     (clk),
      .rst     (rst),
      .req     (req),
      .instr   (instr),
      .ack     (ack),
      .rd_idx  (rd_idx),
      .rb_idx  (rb_idx),
      .rd_data (rd_data),
      .rb_data (rb_data),
      .flags   (flags),
      .issue   (issue)
   );

   reg_file regs_i (
      .clk        (clk),
      .rst        (rst),
      .rd_idx     (rd_idx),
      .rb_idx     (rb_idx),
      .rd_data    (rd_data),
      .rb_data    (rb_data),
      .flags      (flags),
      .reg_we     (reg_we),
      .reg_widx   (reg_widx),
      .reg_wdata  (reg_wdata),
      .flag_we    (flag_we),
      .flag_wdata (flag_wdata)
   );

   alu alu_i (
      .issue   (issue),
      .res     (res),
      .fo      (fo),
      .wb_en   (wb_en),
      .flag_en (flag_en)
   );

   writeback_stage wb_i (
      .clk        (clk),
      .rst        (rst),
      .issue      (issue),
      .res        (res),
      .fo         (fo),
      .wb_en      (wb_en),
      .flag_en    (flag_en),
      .reg_we     (reg_we),
      .reg_widx   (reg_widx),
      .reg_wdata  (reg_wdata),
      .flag_we    (flag_we),
      .flag_wdata (flag_wdata),
      .retire     (retire)
   );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;  // 100 ns period
   end

   initial begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

/* testbench/tb_alu_model.svh */
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

exu_pkg::word_t  mirror_regs [`EXU_NREGS];
exu_pkg::flags_t mirror_flags;

// returns {v, c, sum}, overflow taken from a sign extended sum
function automatic logic [33:0] add_model(exu_pkg::word_t a, exu_pkg::word_t b, logic cin);
   logic [33:0] wide;
   logic [32:0] sum;
   wide = {{2{a[31]}}, a} + {{2{b[31]}}, b} + {33'd0, cin};
   sum  = {1'b0, a} + {1'b0, b} + {32'd0, cin};
   return {wide[32] ^ wide[31], sum};
endfunction

// {wb_en, flag_en} per opcode class
function automatic logic [1:0] enables_model(exu_pkg::op_t op);
   logic [3:0] code;
   logic       wb;
   logic       fl;
   code = op[3:0];
   if (op[5]) begin
      wb = (code < 4'hb) || (code == 4'he);
      fl = (code >= 4'h4) && (code != 4'he);
   end else begin
      wb = (code != 4'h8) && (code != 4'hb) && (code != 4'hc);
      if (!op[4])
         wb = wb && (code != 4'h1) && (code != 4'h2);  // the two pass codes
      fl = (code >= 4'h4) && (code != 4'ha) && (code != 4'hb);
   end
   return {wb, fl};
endfunction

function automatic exu_pkg::retire_t predict(exu_pkg::instr_t ins);
   exu_pkg::retire_t want;
   exu_pkg::word_t   di;
   exu_pkg::word_t   op2;
   exu_pkg::word_t   res;
   exu_pkg::flags_t  fo;
   logic [33:0]      add;
   logic [3:0]       code;
   logic             ci;
   logic [1:0]       en;
   di   = mirror_regs[ins.rd];
   code = ins.op[3:0];
   ci   = mirror_flags[`EXU_CIDX];
   fo   = mirror_flags;
   add  = '0;
   if (ins.op[5:4] == 2'b00)
      op2 = mirror_regs[ins.rb];
   else if (code == 4'hf)
      op2 = {16'hffff, ins.imm};
   else if (code <= 4'h3 || code >= 4'hb)
      op2 = {16'h0000, ins.imm};
   else
      op2 = {{16{ins.imm[15]}}, ins.imm};
   if (ins.op[5]) begin
      case (code)
         4'h0: res = di & 32'h0000_00ff;
         4'h1: res = di & 32'h0000_ffff;
         4'h2: res = {{24{di[7]}}, di[7:0]};
         4'h3: res = {{16{di[15]}}, di[15:0]};
         4'h4: res = ~di;
         4'h5: res = -di;
         4'h6: res = {ci, di[31:1]};
         4'h7: res = {di[30:0], ci};
         4'h8: res = di << 1;
         4'h9: res = di >> 1;
         4'ha: res = $signed(di) >>> 1;
         4'he: res = {24'h0, mirror_flags};
         default: res = di;
      endcase
      case (code)
         4'h5: fo[`EXU_CIDX] = (di == 0);  // no borrow from 0 - di
         4'h6, 4'h9, 4'ha: fo[`EXU_CIDX] = di[0];
         4'h7, 4'h8: fo[`EXU_CIDX] = di[31];
         4'hc: fo[`EXU_CIDX] = 1'b1;
         4'hd: fo[`EXU_CIDX] = 1'b0;
         default: ;
      endcase
   end else begin
      case (code)
         4'h0: res = ins.op[4] ? {di[31:16], ins.imm} : op2;
         4'h1: res = ins.op[4] ? {ins.imm, di[15:0]} : di;
         4'h2: res = ins.op[4] ? op2 : di;
         4'h3: res = {32{op2[31]}};
         4'h4, 4'ha: add = add_model(di, op2, 1'b0);
         4'h5: add = add_model(di, op2, ci);
         4'h6, 4'h8: add = add_model(di, ~op2, 1'b1);
         4'h7: add = add_model(di, ~op2, ci);
         4'h9: res = di * op2;
         4'hd: res = di | op2;
         4'he: res = di ^ op2;
         default: res = di & op2;
      endcase
      if ((code >= 4'h4 && code <= 4'h8) || code == 4'ha)
         res = add[31:0];
      if (code >= 4'h4 && code <= 4'h8) begin
         fo[`EXU_CIDX] = add[32];
         fo[`EXU_VIDX] = add[33];
      end
   end
   fo[`EXU_ZIDX] = (res == 0);
   fo[`EXU_SIDX] = res[31];
   if (ins.op == 6'h2f)
      fo = di[7:0];
   en              = enables_model(ins.op);
   want.valid      = 1'b1;
   want.rd         = ins.rd;
   want.data       = res;
   want.flags      = en[0] ? fo : mirror_flags;
   want.wb_en      = en[1];
   want.flag_en    = en[0];
   return want;
endfunction

task automatic commit_model(exu_pkg::retire_t want);
   if (want.wb_en)
      mirror_regs[want.rd] = want.data;
   mirror_flags = want.flags;
endtask

`endif

/* testbench/tb_exec_unit.sv */
`timescale 1ns/10ps
`include "exu_macros.svh"

module tb_exec_unit;

   logic             clk;
   logic             rst;
   logic             req;
   exu_pkg::instr_t  instr;
   logic             ack;
   exu_pkg::retire_t retire;

   integer seed;
   int     errors;
   int     test_errors;
   int     test_instrs;
   int     tests;
   int     sent;
   int     retired;

   `include "tb_alu_model.svh"

   tb_clock_gen clk_i (
      .clk (clk),
      .rst (rst)
   );

   exec_unit dut_i (
      .clk    (clk),
      .rst    (rst),
      .req    (req),
      .instr  (instr),
      .ack    (ack),
      .retire (retire)
   );

   always @(posedge clk) begin
      if (!rst && retire.valid)
         retired++;
   end

   task automatic compare(string name, logic [31:0] want, logic [31:0] got);
      if (got !== want) begin
         $display("** Error at %0t ns: %s expected %h got %h", $time, name, want, got);
         test_errors++;
      end
   endtask

   // one four-phase transfer and its retire report
   task automatic execute(exu_pkg::instr_t ins);
      exu_pkg::retire_t want;
      int               cyc;
      int               ack_at;
      want  = predict(ins);
      req   <= 1'b1;
      instr <= ins;
      sent++;
      test_instrs++;
      cyc = 0;
      while (!ack && cyc < 20) begin
         @(posedge clk);
         cyc++;
      end
      if (!ack) begin
         $display("ack did not rise within 20 cycles for op %h", ins.op);
         test_errors++;
         req <= 1'b0;
         return;
      end
      ack_at = cyc;
      req <= 1'b0;
      @(posedge clk);
      cyc++;
      compare("ack while req high", 1, ack);
      while (!retire.valid && cyc < ack_at + 20) begin
         @(posedge clk);
         cyc++;
      end
      if (!retire.valid) begin
         $display("no retire within 20 cycles of ack for op %h", ins.op);
         test_errors++;
         return;
      end
      compare("retire delay after ack", 2, cyc - ack_at);
      compare("retire.rd", want.rd, retire.rd);
      compare("retire.data", want.data, retire.data);
      compare("retire.flags", want.flags, retire.flags);
      compare("retire.wb_en", want.wb_en, retire.wb_en);
      compare("retire.flag_en", want.flag_en, retire.flag_en);
      @(posedge clk);
      compare("retire.valid after one cycle", 0, retire.valid);
      cyc = 0;
      while (ack && cyc < 20) begin
         @(posedge clk);
         cyc++;
      end
      if (ack) begin
         $display("ack stayed high 20 cycles after req fell");
         test_errors++;
      end
      commit_model(want);
   endtask

   task automatic send_random(exu_pkg::op_t op);
      exu_pkg::instr_t ins;
      ins.op  = op;
      ins.rd  = 4'($random(seed));
      ins.rb  = 4'($random(seed));
      ins.imm = 16'($random(seed));
      execute(ins);
   endtask

   task automatic finish_test(string name);
      $display("%-10s %0d instructions, %0d errors", name, test_instrs, test_errors);
      errors      += test_errors;
      tests++;
      test_errors = 0;
      test_instrs = 0;
   endtask

   initial begin
      exu_pkg::instr_t ins;
      int              n;
      int              pick;
      seed         = 93436;
      errors       = 0;
      test_errors  = 0;
      test_instrs  = 0;
      tests        = 0;
      sent         = 0;
      retired      = 0;
      req          = 1'b0;
      instr        = '0;
      mirror_flags = '0;
      for (int i = 0; i < `EXU_NREGS; i++)
         mirror_regs[i] = '0;

      @(posedge clk);
      n = 0;
      while (rst && n < 10) begin
         @(posedge clk);
         n++;
      end
      if (rst) begin
         $display("reset stayed high for 10 cycles");
         test_errors++;
      end
      compare("ack", 0, ack);
      compare("retire.valid", 0, retire.valid);
      for (int r = 0; r < `EXU_NREGS; r++) begin
         ins = {6'h01, 4'(r), 4'(r), 16'h0000};  // pass di
         execute(ins);
      end
      finish_test("reset");

      for (int i = 0; i < 40; i++)
         send_random(6'h10 + 6'({$random(seed)} % 4));
      finish_test("imm_load");

      for (int i = 0; i < 60; i++) begin
         pick = {$random(seed)} % 12;
         if (pick >= 10)
            send_random(pick == 10 ? 6'h25 : 6'h35);  // negate in both single operand halves
         else
            send_random(6'((pick / 5) * 16 + 4 + pick % 5));
      end
      finish_test("arith");

      for (int i = 0; i < 80; i++) begin
         pick = {$random(seed)} % 33;
         if (pick < 14)
            send_random(6'((pick / 7) * 16 + 9 + pick % 7));
         else if (pick < 29)
            send_random(6'h20 + 6'(pick - 14) + 6'(({$random(seed)} % 2) * 16));
         else
            send_random(6'(pick - 29));  // move, pass and sign-fill
      end
      finish_test("logic");

      for (int i = 0; i < 8; i++) begin
         ins = {6'h10, 4'($random(seed)), 4'h0, 16'($random(seed))};
         execute(ins);
         ins.op = 6'h2f;
         execute(ins);
         ins.op = 6'h2e;
         ins.rd = 4'($random(seed));
         execute(ins);
      end
      finish_test("flags");

      for (int i = 0; i < 20; i++)
         send_random(6'({$random(seed)} % 64));
      repeat (5) @(posedge clk);
      compare("retire count", sent, retired);
      finish_test("handshake");

      $display("%0d tests, %0d instructions, %0d errors", tests, sent, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* compile.f */
+incdir+source
+incdir+testbench
source/exu_pkg.sv
source/issue_stage.sv
source/reg_file.sv
source/alu.sv
source/writeback_stage.sv
source/exec_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_exec_unit.sv
